/* filelist.f */
+incdir+include
hdl/loader_pkg.sv
hdl/slot_timer.sv
hdl/file_parser.sv
hdl/load_addr_unit.sv
hdl/loader_top.sv
test/loader_tb.sv

/* hdl/file_parser.sv */
//======================================================================
// Download byte classifier for program files and cartridge images
// Issues load-address commands, bank descriptions and attach state
//======================================================================

module file_parser
	import loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset_n,
	input  logic       dl_active_i,
	input  file_kind_e dl_index_i,
	input  host_byte_t dl_byte_i,
	output addr_cmd_t  addr_cmd_o,
	output bank_info_t bank_info_o,
	output logic       bank_valid_o,
	output cart_info_t cart_info_o,
	output logic       cart_attached_o
);

	parse_state_e state_q;
	logic         dl_active_q;
	logic [3:0]   hdr_cnt_q;
	logic [31:0]  blk_len_q;
	addr_cmd_t    cmd_q;
	bank_info_t   bank_q;
	cart_info_t   cart_q;
	logic         bank_valid_q;
	logic         attached_q;
	logic         dl_start;
	logic         dl_end;
	logic         crt_path;

	assign dl_start = dl_active_i & ~dl_active_q;
	assign dl_end   = ~dl_active_i & dl_active_q;
	assign crt_path = state_q inside {PARSE_CRT_FILE_HDR, PARSE_CRT_CHIP_HDR,
		PARSE_CRT_CHIP_DATA};

	//======================================================================
	// Control FSM and command pulses
	//======================================================================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state_q      <= PARSE_IDLE;
			dl_active_q  <= 1'b0;
			hdr_cnt_q    <= '0;
			cmd_q        <= '0;
			bank_valid_q <= 1'b0;
			attached_q   <= 1'b0;
		end else begin
			dl_active_q  <= dl_active_i;
			cmd_q        <= '0;
			cmd_q.data   <= dl_byte_i.data;
			bank_valid_q <= 1'b0;
			if (dl_start) begin
				hdr_cnt_q <= '0;
				case (dl_index_i)
					FILE_PRG: state_q <= PARSE_PRG_ADDR;
					FILE_CRT: state_q <= PARSE_CRT_FILE_HDR;
					default:  state_q <= PARSE_IDLE;
				endcase
			end else if (dl_end) begin
				if (crt_path)
					attached_q <= 1'b1;
				state_q <= PARSE_IDLE;
			end else if (dl_byte_i.wr) begin
				case (state_q)
					PARSE_PRG_ADDR: begin
						// Load address comes low byte first
						if (dl_byte_i.addr == '0) begin
							cmd_q.set_lo <= 1'b1;
						end else begin
							cmd_q.set_hi <= 1'b1;
							state_q      <= PARSE_PRG_DATA;
						end
					end
					PARSE_PRG_DATA: cmd_q.push <= 1'b1;
					PARSE_CRT_FILE_HDR: begin
						if (dl_byte_i.addr == '0)
							cmd_q.set_base <= 1'b1;
						if (dl_byte_i.addr == CRT_DATA_START - 1'b1)
							state_q <= PARSE_CRT_CHIP_HDR;
					end
					PARSE_CRT_CHIP_HDR: begin
						hdr_cnt_q <= hdr_cnt_q + 4'd1;
						if (hdr_cnt_q == 4'd0)
							cmd_q.align <= 1'b1;
						if (hdr_cnt_q == 4'd15) begin
							bank_valid_q <= 1'b1;
							// Empty packet goes straight to the next header
							state_q <= (blk_len_q == '0) ? PARSE_CRT_CHIP_HDR
								: PARSE_CRT_CHIP_DATA;
						end
					end
					PARSE_CRT_CHIP_DATA: begin
						cmd_q.push <= 1'b1;
						if (blk_len_q == 32'd1)
							state_q <= PARSE_CRT_CHIP_HDR;
					end
					default: ;
				endcase
			end
		end
	end

	//======================================================================
	// Header field capture
	//======================================================================

	always_ff @(posedge clk_sys) begin
		if (dl_byte_i.wr) begin
			case (state_q)
				PARSE_CRT_FILE_HDR: begin
					case (dl_byte_i.addr)
						CRT_ID_OFS:         cart_q.id[15:8] <= dl_byte_i.data;
						CRT_ID_OFS + 1'b1:  cart_q.id[7:0]  <= dl_byte_i.data;
						CRT_EXROM_OFS:      cart_q.exrom    <= dl_byte_i.data;
						CRT_GAME_OFS:       cart_q.game     <= dl_byte_i.data;
						default: ;
					endcase
				end
				PARSE_CRT_CHIP_HDR: begin
					// Packet length is big-endian and includes the header
					case (hdr_cnt_q)
						4'd4:  blk_len_q[31:24]        <= dl_byte_i.data;
						4'd5:  blk_len_q[23:16]        <= dl_byte_i.data;
						4'd6:  blk_len_q[15:8]         <= dl_byte_i.data;
						4'd7:  blk_len_q[7:0]          <= dl_byte_i.data;
						4'd8:  blk_len_q <= blk_len_q - 32'(CHIP_HDR_LEN);
						4'd9:  bank_q.bank_type        <= dl_byte_i.data;
						4'd10: bank_q.bank_num[15:8]   <= dl_byte_i.data;
						4'd11: bank_q.bank_num[7:0]    <= dl_byte_i.data;
						4'd12: bank_q.load_addr[15:8]  <= dl_byte_i.data;
						4'd13: bank_q.load_addr[7:0]   <= dl_byte_i.data;
						4'd14: bank_q.size[15:8]       <= dl_byte_i.data;
						4'd15: bank_q.size[7:0]        <= dl_byte_i.data;
						default: ;
					endcase
				end
				PARSE_CRT_CHIP_DATA: blk_len_q <= blk_len_q - 32'd1;
				default: ;
			endcase
		end
	end

	assign addr_cmd_o      = cmd_q;
	assign bank_info_o     = bank_q;
	assign bank_valid_o    = bank_valid_q;
	assign cart_info_o     = cart_q;
	assign cart_attached_o = attached_q;

	// A data byte never moves the load address in the same cycle
	a_push_excl: assert property (@(posedge clk_sys) disable iff (!reset_n)
		cmd_q.push |-> !(cmd_q.set_lo || cmd_q.set_hi || cmd_q.set_base || cmd_q.align))
		else $error("push issued together with an address command");

endmodule

/* hdl/load_addr_unit.sv */
//======================================================================
// Load-address register and single-byte write buffer
//======================================================================

module load_addr_unit
	import loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  addr_cmd_t addr_cmd_i,
	input  logic      slot_start_i,
	output mem_wr_t   mem_wr_o,
	output logic      busy_o
);

	logic [ADDR_W-1:0] load_addr_q;
	logic [DATA_W-1:0] wr_data_q;
	logic              pending_q;
	logic              wr_fire;

	// Pending byte goes out in the first slot we are given
	assign wr_fire = pending_q & slot_start_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			load_addr_q <= '0;
			pending_q   <= 1'b0;
		end else begin
			if (wr_fire) begin
				load_addr_q <= load_addr_q + 1'b1;
				pending_q   <= 1'b0;
			end else if (addr_cmd_i.set_lo) begin
				// Program addresses live in the low 64 KB
				load_addr_q <= ADDR_W'(addr_cmd_i.data);
			end else if (addr_cmd_i.set_hi) begin
				load_addr_q[15:8] <= addr_cmd_i.data;
			end else if (addr_cmd_i.set_base) begin
				load_addr_q <= CRT_BASE;
			end else if (addr_cmd_i.align) begin
				// Round up to the next bank
				// An aligned address stays put
				if (load_addr_q[ALIGN_BITS-1:0] != '0) begin
					load_addr_q[ALIGN_BITS-1:0]      <= '0;
					load_addr_q[ADDR_W-1:ALIGN_BITS] <=
						load_addr_q[ADDR_W-1:ALIGN_BITS] + 1'b1;
				end
			end
			if (addr_cmd_i.push)
				pending_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (addr_cmd_i.push)
			wr_data_q <= addr_cmd_i.data;
	end

	assign mem_wr_o = '{we: wr_fire, addr: load_addr_q, data: wr_data_q};

	// Host sees busy from the push until the write leaves
	assign busy_o = (pending_q & ~slot_start_i) | addr_cmd_i.push;

	//======================================================================
	// Checks
	//======================================================================

	// Writes only inside the loader slot
	a_we_in_slot: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_wr_o.we |-> slot_start_i)
		else $error("memory write outside the loader slot");

	// Host honours busy, so a new byte never lands on a pending one
	a_no_overrun: assert property (@(posedge clk_sys) disable iff (!reset_n)
		addr_cmd_i.push |-> !pending_q)
		else $error("byte pushed while previous byte still pending");

endmodule

/* hdl/loader_pkg.sv */
//======================================================================
// Shared widths, loader constants, enums and packed structs
// for the download loader
//======================================================================

package loader_pkg;

	//======================================================================
	// Widths and memory timing
	//======================================================================

	localparam int ADDR_W      = 25;
	localparam int DATA_W      = 8;
	localparam int SLOT_PERIOD = 16;
	localparam int SLOT_PHASE  = 11;
	localparam int PHASE_W     = $clog2(SLOT_PERIOD);

	//======================================================================
	// Cartridge image layout
	//======================================================================

	localparam logic [ADDR_W-1:0] CRT_BASE       = 25'h100000;
	localparam logic [ADDR_W-1:0] CRT_DATA_START = 25'h40;
	localparam int                CHIP_HDR_LEN   = 16;
	// 8 KB bank boundary
	localparam int                ALIGN_BITS     = 13;

	// File header fields, id is stored high byte first
	localparam logic [ADDR_W-1:0] CRT_ID_OFS     = 25'h16;
	localparam logic [ADDR_W-1:0] CRT_EXROM_OFS  = 25'h18;
	localparam logic [ADDR_W-1:0] CRT_GAME_OFS   = 25'h19;

	// Host file index, as sent by the menu
	typedef enum logic [7:0] {
		FILE_OTHER = 8'd0,
		FILE_PRG   = 8'd2,
		FILE_CRT   = 8'd3
	} file_kind_e;

	typedef enum logic [2:0] {
		PARSE_IDLE,
		PARSE_PRG_ADDR,
		PARSE_PRG_DATA,
		PARSE_CRT_FILE_HDR,
		PARSE_CRT_CHIP_HDR,
		PARSE_CRT_CHIP_DATA
	} parse_state_e;

	// One download byte and its strobe
	typedef struct packed {
		logic              wr;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} host_byte_t;

	// Parser to address unit, all flags are single-cycle pulses
	typedef struct packed {
		logic              set_lo;
		logic              set_hi;
		logic              set_base;
		logic              align;
		logic              push;
		logic [DATA_W-1:0] data;
	} addr_cmd_t;

	typedef struct packed {
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} mem_wr_t;

	typedef struct packed {
		logic [7:0]  bank_type;
		logic [15:0] bank_num;
		logic [15:0] load_addr;
		logic [15:0] size;
	} bank_info_t;

	typedef struct packed {
		logic [15:0] id;
		logic [7:0]  exrom;
		logic [7:0]  game;
	} cart_info_t;

endpackage

/* hdl/loader_top.sv */
//======================================================================
// Download loader top with slot timer, parser and address unit
//======================================================================

module loader_top
	import loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset_n,
	input  logic       dl_active_i,
	input  file_kind_e dl_index_i,
	input  host_byte_t dl_byte_i,
	output mem_wr_t    mem_wr_o,
	output logic       busy_o,
	output bank_info_t bank_info_o,
	output logic       bank_valid_o,
	output cart_info_t cart_info_o,
	output logic       cart_attached_o
);

	logic      slot_start;
	addr_cmd_t addr_cmd;

	slot_timer slot_timer_inst (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.slot_start_o (slot_start)
	);

	file_parser file_parser_inst (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_byte_i       (dl_byte_i),
		.addr_cmd_o      (addr_cmd),
		.bank_info_o     (bank_info_o),
		.bank_valid_o    (bank_valid_o),
		.cart_info_o     (cart_info_o),
		.cart_attached_o (cart_attached_o)
	);

	// Memory side, one byte in flight at a time
	load_addr_unit load_addr_unit_inst (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.addr_cmd_i   (addr_cmd),
		.slot_start_i (slot_start),
		.mem_wr_o     (mem_wr_o),
		.busy_o       (busy_o)
	);

endmodule

/* hdl/slot_timer.sv */
//======================================================================
// Memory phase counter with the loader's write-slot pulse
//======================================================================

module slot_timer
	import loader_pkg::*;
(
	input  logic clk_sys,
	input  logic reset_n,
	output logic slot_start_o
);

	logic [PHASE_W-1:0] phase_q;

	// Free-running phase, one full turn per memory cycle
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			phase_q <= '0;
		end else if (phase_q == PHASE_W'(SLOT_PERIOD - 1)) begin
			phase_q <= '0;
		end else begin
			phase_q <= phase_q + 1'b1;
		end
	end

	// The loader owns memory in exactly one phase of the cycle
	assign slot_start_o = (phase_q == PHASE_W'(SLOT_PHASE));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the loader testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module loader_tb -o loader_sim > build.log 2>&1 \
	&& ./obj_dir/loader_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "result: failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "result: no verdict"; exit 1; }
echo "result: passed"
exit 0

/* include/loader_tb_table.svh */
//======================================================================
// Download scenarios with expected write bases, counts and flags
//======================================================================

`ifndef LOADER_TB_TABLE_SVH
`define LOADER_TB_TABLE_SVH

// len_a is the program payload, the first packet payload or the raw byte count
typedef struct packed {
	file_kind_e  kind;
	logic [15:0] prg_addr;
	logic [15:0] len_a;
	logic [15:0] len_b;
	logic [24:0] base_a;
	logic [24:0] base_b;
	logic [15:0] n_wr;
	logic [3:0]  n_bank;
	logic        attached;
} scen_t;

localparam int N_SCEN = 4;

// Header fields carried by every cartridge image
localparam logic [15:0] CART_ID    = 16'h0a13;
localparam logic [7:0]  CART_EXROM = 8'h01;
localparam logic [7:0]  CART_GAME  = 8'h00;

//======================================================================
// kind, load addr, len a, len b, base a, base b, writes, banks, attached
//======================================================================
localparam scen_t SCEN_TAB [N_SCEN] = '{
	'{FILE_CRT,   16'h0000, 16'd32, 16'd0, 25'h100000, 25'h000000, 16'd32, 4'd1, 1'b1},
	// Second packet lands on the next 8 KB bank
	'{FILE_CRT,   16'h0000, 16'd24, 16'd8, 25'h100000, 25'h102000, 16'd32, 4'd2, 1'b1},
	// Program after a cartridge keeps the attach flag
	'{FILE_PRG,   16'hc000, 16'd18, 16'd0, 25'h00c000, 25'h000000, 16'd18, 4'd0, 1'b1},
	'{FILE_OTHER, 16'h0000, 16'd10, 16'd0, 25'h000000, 25'h000000, 16'd0,  4'd0, 1'b1}
};

`endif

/* test/loader_tb.sv */
//======================================================================
// Download loader testbench with clock, reset, scenario loop,
// write monitor, value check and report
//======================================================================

module loader_tb
	import loader_pkg::*;
();

	`include "loader_tb_table.svh"

	logic       clk_sys;
	logic       reset_n;
	logic       dl_active;
	file_kind_e dl_index;
	host_byte_t dl_byte;
	mem_wr_t    mem_wr;
	logic       busy;
	bank_info_t bank_info;
	logic       bank_valid;
	cart_info_t cart_info;
	logic       cart_attached;

	integer seed;
	int     errors;
	int     test_errors;
	int     tests_failed;

	// Download image and what it must cause
	logic [7:0]        file_q[$];
	logic              payload_q[$];
	logic [ADDR_W-1:0] exp_addr_q[$];
	logic [7:0]        exp_data_q[$];
	bank_info_t        exp_bank_q[$];
	mem_wr_t           got_wr_q[$];
	bank_info_t        got_bank_q[$];

	loader_top loader_top_inst (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active),
		.dl_index_i      (dl_index),
		.dl_byte_i       (dl_byte),
		.mem_wr_o        (mem_wr),
		.busy_o          (busy),
		.bank_info_o     (bank_info),
		.bank_valid_o    (bank_valid),
		.cart_info_o     (cart_info),
		.cart_attached_o (cart_attached)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Write and bank monitor on the falling edge
	always @(negedge clk_sys) begin
		if (reset_n && mem_wr.we)
			got_wr_q.push_back(mem_wr);
		if (reset_n && bank_valid)
			got_bank_q.push_back(bank_info);
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, expected);
			test_errors++;
		end
	endtask

	task automatic end_run();
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	// Pending byte must leave within one memory cycle
	task automatic wait_not_busy();
		int cycles;
		cycles = 0;
		while (busy) begin
			if (cycles > 2 * SLOT_PERIOD) begin
				$display("Timeout: busy_o still high after %0d cycles", cycles);
				errors++;
				end_run();
			end
			@(negedge clk_sys);
			cycles++;
		end
	endtask

	task automatic send_byte(input int ofs, input logic [7:0] value, input logic payload);
		dl_byte = '{wr: 1'b1, addr: ADDR_W'(ofs), data: value};
		@(negedge clk_sys);
		dl_byte.wr = 1'b0;
		check_value("busy_o", busy, payload);
		wait_not_busy();
		// Busy falls in the cycle of the write
		check_value("mem_wr_o.we", mem_wr.we, payload);
	endtask

	task automatic add_byte(input logic [7:0] value, input logic payload);
		file_q.push_back(value);
		payload_q.push_back(payload);
	endtask

	task automatic add_payload(input int len, input logic [ADDR_W-1:0] base);
		logic [7:0] b;
		for (int i = 0; i < len; i++) begin
			b = 8'($random(seed));
			add_byte(b, 1'b1);
			exp_addr_q.push_back(base + ADDR_W'(i));
			exp_data_q.push_back(b);
		end
	endtask

	// Chip packet with its 16-byte header
	task automatic add_chip(input int num, input int len, input logic [ADDR_W-1:0] base);
		bank_info_t   bank;
		logic [127:0] hdr;
		bank.bank_type = 8'h02;
		bank.bank_num  = 16'(num);
		bank.load_addr = 16'h8000 | (16'(num) << 13);
		bank.size      = 16'(len);
		// Signature, big-endian length with header, chip type high byte
		hdr = {32'h4348_4950, 32'(len + CHIP_HDR_LEN), 8'h00, bank};
		for (int i = 0; i < CHIP_HDR_LEN; i++)
			add_byte(hdr[127 - 8 * i -: 8], 1'b0);
		exp_bank_q.push_back(bank);
		add_payload(len, base);
	endtask

	task automatic build_file(input scen_t s);
		logic [7:0] b;
		file_q.delete();
		payload_q.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
		exp_bank_q.delete();
		case (s.kind)
			FILE_PRG: begin
				add_byte(s.prg_addr[7:0], 1'b0);
				add_byte(s.prg_addr[15:8], 1'b0);
				add_payload(s.len_a, s.base_a);
			end
			FILE_CRT: begin
				for (int ofs = 0; ofs < int'(CRT_DATA_START); ofs++) begin
					// Filler follows the offset so a misplaced capture shows up
					b = 8'h80 | 8'(ofs);
					if (ofs == int'(CRT_ID_OFS))
						b = CART_ID[15:8];
					if (ofs == int'(CRT_ID_OFS) + 1)
						b = CART_ID[7:0];
					if (ofs == int'(CRT_EXROM_OFS))
						b = CART_EXROM;
					if (ofs == int'(CRT_GAME_OFS))
						b = CART_GAME;
					add_byte(b, 1'b0);
				end
				add_chip(0, s.len_a, s.base_a);
				if (s.len_b != 0)
					add_chip(1, s.len_b, s.base_b);
			end
			default: begin
				for (int i = 0; i < s.len_a; i++)
					add_byte(8'($random(seed)), 1'b0);
			end
		endcase
	endtask

	//======================================================================
	// One table row: download, then compare writes and side outputs
	//======================================================================
	task automatic run_scenario(input int idx);
		scen_t      s;
		file_kind_e kind;
		s = SCEN_TAB[idx];
		kind = s.kind;
		test_errors = 0;
		build_file(s);
		got_wr_q.delete();
		got_bank_q.delete();
		dl_index = kind;
		dl_active = 1'b1;
		@(negedge clk_sys);
		foreach (file_q[i])
			send_byte(i, file_q[i], payload_q[i]);
		dl_active = 1'b0;
		// Attach flag follows the falling download level by one cycle
		@(negedge clk_sys);
		check_value("mem_wr_o.we count", got_wr_q.size(), s.n_wr);
		check_value("bank_valid_o count", got_bank_q.size(), s.n_bank);
		check_value("cart_attached_o", cart_attached, s.attached);
		foreach (got_wr_q[i]) begin
			if (i < exp_addr_q.size()) begin
				check_value("mem_wr_o.addr", got_wr_q[i].addr, exp_addr_q[i]);
				check_value("mem_wr_o.data", got_wr_q[i].data, exp_data_q[i]);
			end
		end
		foreach (got_bank_q[i]) begin
			if (i < exp_bank_q.size()) begin
				check_value("bank_info_o.bank_type", got_bank_q[i].bank_type,
					exp_bank_q[i].bank_type);
				check_value("bank_info_o.bank_num", got_bank_q[i].bank_num,
					exp_bank_q[i].bank_num);
				check_value("bank_info_o.load_addr", got_bank_q[i].load_addr,
					exp_bank_q[i].load_addr);
				check_value("bank_info_o.size", got_bank_q[i].size, exp_bank_q[i].size);
			end
		end
		if (kind == FILE_CRT) begin
			check_value("cart_info_o.id", cart_info.id, CART_ID);
			check_value("cart_info_o.exrom", cart_info.exrom, CART_EXROM);
			check_value("cart_info_o.game", cart_info.game, CART_GAME);
		end
		errors += test_errors;
		if (test_errors != 0)
			tests_failed++;
		$display("test %0d %s: %0d bytes, %0d writes, %0d errors", idx + 1, kind.name(),
			file_q.size(), got_wr_q.size(), test_errors);
	endtask

	initial begin
		seed = 62534;
		errors = 0;
		tests_failed = 0;
		reset_n = 1'b0;
		dl_active = 1'b0;
		dl_index = FILE_OTHER;
		dl_byte = '0;
		repeat (16) @(negedge clk_sys);
		reset_n = 1'b1;

		// Outputs stay quiet after reset
		test_errors = 0;
		repeat (20) begin
			@(negedge clk_sys);
			check_value("mem_wr_o.we", mem_wr.we, 1'b0);
			check_value("busy_o", busy, 1'b0);
			check_value("bank_valid_o", bank_valid, 1'b0);
			check_value("cart_attached_o", cart_attached, 1'b0);
		end
		errors += test_errors;
		if (test_errors != 0)
			tests_failed++;
		$display("test 0 reset idle: %0d errors", test_errors);

		for (int i = 0; i < N_SCEN; i++)
			run_scenario(i);

		$display("tests run %0d, tests failed %0d, errors %0d", N_SCEN + 1, tests_failed,
			errors);
		end_run();
	end

endmodule
